//--- flist.f
verilog/cp0_pkg.sv
verilog/cp0_commit_if.sv
verilog/cp0_commit_ctrl.sv
verilog/cp0_status_regs.sv
verilog/cp0_cause_regs.sv
verilog/cp0_timer.sv
verilog/cp0_read_mux.sv
verilog/cp0_top.sv
tb/cp0_assertions.sv
tb/cp0_tb.sv

//--- tb/cp0_tb.sv
`timescale 1ns/1ps

module cp0_tb;

    localparam logic [7:0]  A_BADVADDR = {5'd8, 3'd0};
    localparam logic [7:0]  A_COUNT    = {5'd9, 3'd0};
    localparam logic [7:0]  A_COMPARE  = {5'd11, 3'd0};
    localparam logic [7:0]  A_STATUS   = {5'd12, 3'd0};
    localparam logic [7:0]  A_CAUSE    = {5'd13, 3'd0};
    localparam logic [7:0]  A_EPC      = {5'd14, 3'd0};
    localparam logic [7:0]  A_PRID     = {5'd15, 3'd0};
    localparam logic [7:0]  A_EBASE    = {5'd15, 3'd1};
    localparam logic [31:0] EBASE_INIT = 32'h8000_0000;
    localparam logic [31:0] PRID       = 32'h0000_4220;

    logic clk;
    logic reset;
    logic [4:0] m1s_rd;
    logic [2:0] m1s_sel;
    logic m1s_valid;
    logic m1s_inst_mtc0;
    logic m1s_inst_eret;
    logic m1s_bd;
    logic m1s_ex;
    cp0_pkg::exc_type_t m1s_exc_type;
    logic [31:0] m1s_alu_result;
    logic [31:0] m1s_pc;
    logic [5:0] ext_int;
    logic [31:0] cp0_rdata;
    logic eret_flush;
    logic [31:0] epc;
    logic status_ie;
    logic status_exl;
    logic [7:0] status_im;
    logic [7:0] cause_ip;
    logic cause_ti;
    logic [31:0] exception_addr;

    logic [31:0] lfsr;
    string test_name;

    // Reference model state
    logic m_cu0, m_bev, m_erl, m_exl, m_ie, m_bd, m_ti, m_tick;
    logic [7:0] m_im;
    logic [5:0] m_ext_q;
    logic [1:0] m_sw_ip;
    logic [4:0] m_code;
    logic [31:0] m_ebase, m_epc, m_badv, m_count, m_compare;

    cp0_top #(.EBASE_RESET(EBASE_INIT), .PRID_VALUE(PRID)) i_dut (.*);

    always #10 clk = ~clk;

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [7:0] addr_at(input logic [3:0] idx);
        case (idx)
            4'd0: return A_BADVADDR;
            4'd1: return A_COUNT;
            4'd2: return A_COMPARE;
            4'd3: return A_STATUS;
            4'd4: return A_CAUSE;
            4'd5: return A_EPC;
            4'd6: return A_PRID;
            4'd7: return A_EBASE;
            default: return 8'h08; // Not implemented
        endcase
    endfunction

    function automatic logic [4:0] code_for(input logic [4:0] t);
        case (t)
            5'd1: return 5'd0;   // Int
            5'd2: return 5'd4;   // AdEL
            5'd3: return 5'd5;   // AdES
            5'd4: return 5'd8;
            5'd5: return 5'd9;
            5'd6: return 5'd10;
            5'd7: return 5'd11;
            5'd8: return 5'd12;
            5'd9: return 5'd13;  // Trap
            default: return 5'd31;
        endcase
    endfunction

    function automatic logic [7:0] model_ip();
        return {m_ext_q[5] | m_ti, m_ext_q[4:0], m_sw_ip};
    endfunction

    function automatic logic [31:0] model_read(input logic [7:0] a);
        case (a)
            A_BADVADDR: return m_badv;
            A_COUNT:    return m_count;
            A_COMPARE:  return m_compare;
            A_STATUS:   return {3'b0, m_cu0, 5'b0, m_bev, 6'b0, m_im, 5'b0, m_erl, m_exl, m_ie};
            A_CAUSE:    return {m_bd, m_ti, 14'b0, model_ip(), 1'b0, m_code, 2'b00};
            A_EPC:      return m_epc;
            A_PRID:     return PRID;
            A_EBASE:    return m_ebase;
            default:    return 32'd0;
        endcase
    endfunction

    // Called at each rising edge with the inputs of the closing cycle
    task automatic update_model();
        logic [7:0] a;
        logic [31:0] d;
        logic we;
        logic ret;
        logic first_ex;
        a = {m1s_rd, m1s_sel};
        d = m1s_alu_result;
        we = m1s_valid && m1s_inst_mtc0 && !m1s_ex;
        ret = m1s_valid && m1s_inst_eret && !m1s_ex;
        first_ex = m1s_ex && !m_exl;
        if (reset) begin
            {m_cu0, m_erl, m_exl, m_ie, m_bd, m_ti, m_tick} = '0;
            m_bev = 1'b1;
            {m_im, m_ext_q, m_sw_ip} = '0;
            m_code = 5'd31;
            {m_epc, m_badv, m_count} = '0;
            m_ebase = EBASE_INIT;
            m_compare = 32'hffff_ffff;
        end else begin
            if (we && a == A_COMPARE) m_ti = 1'b0;
            else if (m_count == m_compare) m_ti = 1'b1; // Old Count and Compare
            if (we && a == A_COUNT) m_count = d;
            else if (m_tick) m_count = m_count + 32'd1;
            m_tick = !m_tick;
            if (we && a == A_COMPARE) m_compare = d;
            if (we && a == A_STATUS) begin
                {m_cu0, m_bev, m_im, m_erl, m_ie} = {d[28], d[22], d[15:8], d[2], d[0]};
            end
            if (m1s_ex) m_exl = 1'b1;
            else if (ret) m_exl = 1'b0;
            else if (we && a == A_STATUS) m_exl = d[1];
            if (we && a == A_EBASE) m_ebase[29:12] = d[29:12];
            if (first_ex) begin
                m_bd = m1s_bd;
                m_epc = m1s_bd ? m1s_pc - 32'd4 : m1s_pc;
            end else if (we && a == A_EPC) begin
                m_epc = d;
            end
            if (m1s_ex) m_code = code_for(m1s_exc_type);
            if (m1s_ex && m1s_exc_type == 5'd3) m_badv = d;
            else if (m1s_ex && m1s_exc_type == 5'd2) m_badv = (m1s_pc[1:0] != 2'b00) ? m1s_pc : d;
            m_ext_q = ext_int;
            if (we && a == A_CAUSE) m_sw_ip = d[9:8];
        end
    endtask

    task automatic expect_equal(input string what, input logic [31:0] expected,
                                input logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAIL %s/%s: expected %h, actual %h", test_name, what, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "Mismatch at %0t", $time);
        end
    endtask

    task automatic stop_on_assertion();
        if (i_dut.i_assertions.fail_count != 0) begin
            $display("A bound assertion failed during test %s", test_name);
            $display("TEST FAILED");
            $fatal(1, "Assertion failure at %0t", $time);
        end
    endtask

    task automatic check_outputs();
        expect_equal("mfc0", model_read({m1s_rd, m1s_sel}), cp0_rdata);
        expect_equal("eret_flush", m1s_valid & m1s_inst_eret & ~m1s_ex, eret_flush);
        expect_equal("exception_addr", (m_bev ? 32'hbfc0_0200 : m_ebase) + 32'h180,
                     exception_addr);
        expect_equal("epc", m_epc, epc);
        expect_equal("status bits", {m_im, m_exl, m_ie}, {status_im, status_exl, status_ie});
        expect_equal("cause_ip", model_ip(), cause_ip);
        expect_equal("cause_ti", m_ti, cause_ti);
    endtask

    // One pipeline cycle; side fields are random
    task automatic run_cycle(input logic [7:0] a, input logic valid, mtc0, eret, ex,
                             input logic [31:0] data);
        logic [4:0] exc;
        @(posedge clk);
        update_model();
        exc = rand_bits(4) % 10;
        m1s_rd <= a[7:3];
        m1s_sel <= a[2:0];
        m1s_valid <= valid;
        m1s_inst_mtc0 <= mtc0;
        m1s_inst_eret <= eret;
        m1s_ex <= ex;
        m1s_bd <= rand_bits(1);
        m1s_exc_type <= cp0_pkg::exc_type_t'(exc);
        m1s_alu_result <= data;
        m1s_pc <= rand_bits(32);
        ext_int <= rand_bits(6);
        @(negedge clk);
        check_outputs();
        stop_on_assertion();
    endtask

    task automatic random_cycle();
        logic [1:0] op;
        logic [7:0] a;
        logic valid, mtc0, eret, ex;
        op = rand_bits(2); // 0 mtc0, 1 eret, 2 exception, 3 idle
        a = (rand_bits(3) == 0) ? rand_bits(8) : addr_at(rand_bits(3));
        valid = (rand_bits(2) != 0);
        ex = (op == 2'd2) || (op == 2'd0 && rand_bits(3) == 0);
        mtc0 = (op == 2'd0) || (ex && rand_bits(1));
        eret = (op == 2'd1) || (ex && rand_bits(1));
        run_cycle(a, valid, mtc0, eret, ex, rand_bits(32));
    endtask

    initial begin
        int i;
        int waited;
        lfsr = 32'hbe55;
        test_name = "reset";
        clk = 1'b0;
        reset = 1'b1;
        {m1s_rd, m1s_sel, m1s_valid, m1s_inst_mtc0, m1s_inst_eret, m1s_bd, m1s_ex} = '0;
        m1s_exc_type = cp0_pkg::EXC_NONE;
        {m1s_alu_result, m1s_pc, ext_int} = '0;
        for (i = 0; i < 5; i++) begin
            @(posedge clk);
            update_model();
            if (i == 4) reset <= 1'b0;
        end
        for (i = 0; i < 9; i++) run_cycle(addr_at(i), 1'b0, 1'b0, 1'b0, 1'b0, 32'd0);

        test_name = "timer";
        run_cycle(A_COMPARE, 1'b1, 1'b1, 1'b0, 1'b0, m_count + 32'd8);
        waited = 0;
        while (cause_ti !== 1'b1) begin
            if (waited == 50) begin
                $display("Timer interrupt did not rise within 50 cycles");
                $display("TEST FAILED");
                $fatal(1, "Timeout");
            end
            run_cycle(A_COUNT, 1'b0, 1'b0, 1'b0, 1'b0, 32'd0);
            waited++;
        end
        expect_equal("ip7 with ti", 32'd1, cause_ip[7]);
        run_cycle(A_CAUSE, 1'b1, 1'b1, 1'b0, 1'b0, 32'd0); // Cause write leaves TI alone
        run_cycle(A_COMPARE, 1'b1, 1'b1, 1'b0, 1'b0, 32'd0);
        run_cycle(A_CAUSE, 1'b0, 1'b0, 1'b0, 1'b0, 32'd0); // Compare write lands here
        expect_equal("ti cleared", 32'd0, cause_ti);

        test_name = "random";
        for (i = 0; i < 400; i++) random_cycle();

        if (i_dut.i_assertions.fail_count != 0) begin
            $display("%0d assertion failures were reported", i_dut.i_assertions.fail_count);
            $display("TEST FAILED");
            $fatal(1, "Assertion failures");
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule

//--- tb/cp0_assertions.sv
`timescale 1ns/1ps

module cp0_assertions (
    input logic       clk,
    input logic       reset,
    input logic       m1s_valid,
    input logic       m1s_inst_mtc0,
    input logic       m1s_ex,
    input logic [4:0] m1s_rd,
    input logic [2:0] m1s_sel,
    input logic       eret_flush,
    input logic       status_exl,
    input logic       cause_ti
);

    int fail_count = 0; // Tally of failed properties

    logic compare_write;

    assign compare_write = m1s_valid && m1s_inst_mtc0 && !m1s_ex
                           && ({m1s_rd, m1s_sel} == cp0_pkg::COMPARE);

    a_eret_clears_exl: assert property (@(posedge clk) disable iff (reset)
        eret_flush |=> !status_exl)
        else begin
            fail_count++;
            $error("EXL still set after an ERET flush");
        end

    a_ex_sets_exl: assert property (@(posedge clk) disable iff (reset)
        m1s_ex |=> status_exl)
        else begin
            fail_count++;
            $error("EXL not set after an exception");
        end

    a_compare_clears_ti: assert property (@(posedge clk) disable iff (reset)
        compare_write |=> !cause_ti)
        else begin
            fail_count++;
            $error("cause_ti still high after a Compare write");
        end

endmodule

bind cp0_top cp0_assertions i_assertions (
    .clk           (clk),
    .reset         (reset),
    .m1s_valid     (m1s_valid),
    .m1s_inst_mtc0 (m1s_inst_mtc0),
    .m1s_ex        (m1s_ex),
    .m1s_rd        (m1s_rd),
    .m1s_sel       (m1s_sel),
    .eret_flush    (eret_flush),
    .status_exl    (status_exl),
    .cause_ti      (cause_ti)
);

//--- verilog/cp0_top.sv
`timescale 1ns/1ps

module cp0_top #(
    parameter cp0_pkg::word_t EBASE_RESET = 32'h8000_0000,
    parameter cp0_pkg::word_t PRID_VALUE  = 32'h0000_4220
) (
    input  logic               clk,
    input  logic               reset,
    input  logic [4:0]         m1s_rd,
    input  logic [2:0]         m1s_sel,
    input  logic               m1s_valid,
    input  logic               m1s_inst_mtc0,
    input  logic               m1s_inst_eret,
    input  logic               m1s_bd,
    input  logic               m1s_ex,
    input  cp0_pkg::exc_type_t m1s_exc_type,
    input  cp0_pkg::word_t     m1s_alu_result,
    input  cp0_pkg::word_t     m1s_pc,
    input  logic [5:0]         ext_int,
    output cp0_pkg::word_t     cp0_rdata,
    output logic               eret_flush,
    output cp0_pkg::word_t     epc,
    output logic               status_ie,
    output logic               status_exl,
    output logic [7:0]         status_im,
    output logic [7:0]         cause_ip,
    output logic               cause_ti,
    output cp0_pkg::word_t     exception_addr
);

    cp0_pkg::word_t status;
    cp0_pkg::word_t ebase;
    cp0_pkg::word_t cause;
    cp0_pkg::word_t badvaddr;
    cp0_pkg::word_t count;
    cp0_pkg::word_t compare;
    logic           bev;

    cp0_commit_if commit_bus ();

    cp0_commit_ctrl i_commit_ctrl (
        .m1s_rd         (m1s_rd),
        .m1s_sel        (m1s_sel),
        .m1s_valid      (m1s_valid),
        .m1s_inst_mtc0  (m1s_inst_mtc0),
        .m1s_inst_eret  (m1s_inst_eret),
        .m1s_ex         (m1s_ex),
        .m1s_bd         (m1s_bd),
        .m1s_exc_type   (m1s_exc_type),
        .m1s_alu_result (m1s_alu_result),
        .m1s_pc         (m1s_pc),
        .bev            (bev),
        .ebase          (ebase),
        .commit         (commit_bus.ctrl),
        .eret_flush     (eret_flush),
        .exception_addr (exception_addr)
    );

    cp0_status_regs #(
        .EBASE_RESET (EBASE_RESET)
    ) i_status_regs (
        .clk    (clk),
        .reset  (reset),
        .commit (commit_bus.regs),
        .status (status),
        .ebase  (ebase),
        .exl    (status_exl),
        .bev    (bev),
        .ie     (status_ie),
        .im     (status_im)
    );

    cp0_cause_regs i_cause_regs (
        .clk            (clk),
        .reset          (reset),
        .commit         (commit_bus.regs),
        .m1s_alu_result (m1s_alu_result),
        .ext_int        (ext_int),
        .exl            (status_exl),
        .ti             (cause_ti),
        .cause          (cause),
        .epc            (epc),
        .badvaddr       (badvaddr),
        .ip             (cause_ip)
    );

    cp0_timer i_timer (
        .clk            (clk),
        .reset          (reset),
        .commit         (commit_bus.regs),
        .m1s_alu_result (m1s_alu_result),
        .count          (count),
        .compare        (compare),
        .ti             (cause_ti)
    );

    // mfc0 address comes off the commit bus
    cp0_read_mux #(
        .PRID_VALUE (PRID_VALUE)
    ) i_read_mux (
        .addr     (commit_bus.addr),
        .status   (status),
        .cause    (cause),
        .epc      (epc),
        .badvaddr (badvaddr),
        .count    (count),
        .compare  (compare),
        .ebase    (ebase),
        .ti       (cause_ti),
        .rdata    (cp0_rdata)
    );

endmodule

//--- verilog/cp0_read_mux.sv
`timescale 1ns/1ps

module cp0_read_mux #(
    parameter cp0_pkg::word_t PRID_VALUE = 32'h0000_4220
) (
    input  cp0_pkg::cp0_addr_t addr,
    input  cp0_pkg::word_t     status,
    input  cp0_pkg::word_t     cause,
    input  cp0_pkg::word_t     epc,
    input  cp0_pkg::word_t     badvaddr,
    input  cp0_pkg::word_t     count,
    input  cp0_pkg::word_t     compare,
    input  cp0_pkg::word_t     ebase,
    input  logic               ti,
    output cp0_pkg::word_t     rdata
);

    always_comb begin
        case (addr)
            cp0_pkg::BADVADDR: rdata = badvaddr;
            cp0_pkg::COUNT:    rdata = count;
            cp0_pkg::COMPARE:  rdata = compare;
            cp0_pkg::STATUS:   rdata = status;
            cp0_pkg::CAUSE:    rdata = {cause[31], ti, cause[29:0]}; // TI from the timer
            cp0_pkg::EPC:      rdata = epc;
            cp0_pkg::PRID:     rdata = PRID_VALUE;
            cp0_pkg::EBASE:    rdata = ebase;
            default:           rdata = '0;   // Unimplemented registers
        endcase
    end

endmodule

//--- verilog/cp0_timer.sv
`timescale 1ns/1ps

module cp0_timer (
    input  logic           clk,
    input  logic           reset,
    cp0_commit_if.regs     commit,
    input  cp0_pkg::word_t m1s_alu_result,
    output cp0_pkg::word_t count,
    output cp0_pkg::word_t compare,
    output logic           ti
);

    logic tick;        // High on every other cycle
    logic count_we;
    logic compare_we;

    assign count_we   = commit.mtc0_we && (commit.addr == cp0_pkg::COUNT);
    assign compare_we = commit.mtc0_we && (commit.addr == cp0_pkg::COMPARE);

    always_ff @(posedge clk) begin
        if (reset) begin
            tick    <= 1'b0;
            count   <= '0;
            compare <= cp0_pkg::COMPARE_RESET;
        end else begin
            tick <= ~tick;
            if (count_we) begin
                count <= m1s_alu_result;
            end else if (tick) begin
                count <= count + 32'd1;
            end
            if (compare_we) begin
                compare <= m1s_alu_result;
            end
        end
    end

    // Writing Compare acknowledges the interrupt
    always_ff @(posedge clk) begin
        if (reset) begin
            ti <= 1'b0;
        end else if (compare_we) begin
            ti <= 1'b0;
        end else if (count == compare) begin
            ti <= 1'b1;
        end
    end

endmodule

//--- verilog/cp0_cause_regs.sv
`timescale 1ns/1ps

module cp0_cause_regs (
    input  logic           clk,
    input  logic           reset,
    cp0_commit_if.regs     commit,
    input  cp0_pkg::word_t m1s_alu_result,
    input  logic [5:0]     ext_int,
    input  logic           exl,
    input  logic           ti,
    output cp0_pkg::word_t cause,
    output cp0_pkg::word_t epc,
    output cp0_pkg::word_t badvaddr,
    output logic [7:0]     ip
);

    logic                bd;
    logic [5:0]          ext_q;   // Sampled hardware interrupts
    logic [1:0]          sw_ip;   // Software interrupts
    cp0_pkg::exc_code_t  exc_code;
    logic                first_ex; // Not nested inside a handler

    assign first_ex = commit.ex && !exl;

    always_ff @(posedge clk) begin
        if (reset) begin
            bd  <= 1'b0;
            epc <= '0;
        end else if (first_ex) begin
            bd  <= commit.bd;
            epc <= commit.bd ? commit.pc - 32'd4 : commit.pc; // Back up to the branch
        end else if (commit.mtc0_we && commit.addr == cp0_pkg::EPC) begin
            epc <= commit.wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            exc_code <= cp0_pkg::NO_EX;
        end else if (commit.ex) begin
            case (commit.exc_type)
                cp0_pkg::EXC_INT:  exc_code <= cp0_pkg::EC_INT;
                cp0_pkg::EXC_ADEL: exc_code <= cp0_pkg::EC_ADEL;
                cp0_pkg::EXC_ADES: exc_code <= cp0_pkg::EC_ADES;
                cp0_pkg::EXC_SYS:  exc_code <= cp0_pkg::EC_SYS;
                cp0_pkg::EXC_BP:   exc_code <= cp0_pkg::EC_BP;
                cp0_pkg::EXC_RI:   exc_code <= cp0_pkg::EC_RI;
                cp0_pkg::EXC_CPU:  exc_code <= cp0_pkg::EC_CPU;
                cp0_pkg::EXC_OV:   exc_code <= cp0_pkg::EC_OV;
                cp0_pkg::EXC_TRAP: exc_code <= cp0_pkg::EC_TR;
                default:           exc_code <= cp0_pkg::NO_EX;
            endcase
        end
    end

    // Fetch fault when the PC itself is misaligned, else a load fault
    always_ff @(posedge clk) begin
        if (reset) begin
            badvaddr <= '0;
        end else if (commit.ex && commit.exc_type == cp0_pkg::EXC_ADES) begin
            badvaddr <= m1s_alu_result;
        end else if (commit.ex && commit.exc_type == cp0_pkg::EXC_ADEL) begin
            badvaddr <= (commit.pc[1:0] != 2'b00) ? commit.pc : m1s_alu_result;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ext_q <= 6'b0;
            sw_ip <= 2'b0;
        end else begin
            ext_q <= ext_int;
            if (commit.mtc0_we && commit.addr == cp0_pkg::CAUSE) begin
                sw_ip <= commit.wdata[9:8];
            end
        end
    end

    assign ip    = {ext_q[5] | ti, ext_q[4:0], sw_ip}; // Timer shares IP7
    assign cause = {bd, ti, 14'b0, ip, 1'b0, exc_code, 2'b00};

endmodule

//--- verilog/cp0_status_regs.sv
`timescale 1ns/1ps

module cp0_status_regs #(
    parameter cp0_pkg::word_t EBASE_RESET = 32'h8000_0000
) (
    input  logic           clk,
    input  logic           reset,
    cp0_commit_if.regs     commit,
    output cp0_pkg::word_t status,
    output cp0_pkg::word_t ebase,
    output logic           exl,
    output logic           bev,
    output logic           ie,
    output logic [7:0]     im
);

    logic cu0;
    logic erl;
    logic status_we;
    logic ebase_we;

    assign status_we = commit.mtc0_we && (commit.addr == cp0_pkg::STATUS);
    assign ebase_we  = commit.mtc0_we && (commit.addr == cp0_pkg::EBASE);

    always_ff @(posedge clk) begin
        if (reset) begin
            cu0 <= 1'b0;
            bev <= 1'b1;   // Boot vectors after reset
            im  <= 8'h00;
            erl <= 1'b0;
            ie  <= 1'b0;
        end else if (status_we) begin
            cu0 <= commit.wdata[28];
            bev <= commit.wdata[22];
            im  <= commit.wdata[15:8];
            erl <= commit.wdata[2];
            ie  <= commit.wdata[0];
        end
    end

    // Exception beats ERET, ERET beats software write
    always_ff @(posedge clk) begin
        if (reset) begin
            exl <= 1'b0;
        end else if (commit.ex) begin
            exl <= 1'b1;
        end else if (commit.eret) begin
            exl <= 1'b0;
        end else if (status_we) begin
            exl <= commit.wdata[1];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ebase <= EBASE_RESET;
        end else if (ebase_we) begin
            ebase[29:12] <= commit.wdata[29:12]; // Only the base field is writable
        end
    end

    // UM reads as zero
    assign status = {3'b000, cu0, 5'b00000, bev, 6'b000000, im,
                     5'b00000, erl, exl, ie};

endmodule

//--- verilog/cp0_commit_ctrl.sv
`timescale 1ns/1ps

module cp0_commit_ctrl (
    input  logic [4:0]         m1s_rd,
    input  logic [2:0]         m1s_sel,
    input  logic               m1s_valid,
    input  logic               m1s_inst_mtc0,
    input  logic               m1s_inst_eret,
    input  logic               m1s_ex,
    input  logic               m1s_bd,
    input  cp0_pkg::exc_type_t m1s_exc_type,
    input  cp0_pkg::word_t     m1s_alu_result,
    input  cp0_pkg::word_t     m1s_pc,
    input  logic               bev,
    input  cp0_pkg::word_t     ebase,
    cp0_commit_if.ctrl         commit,
    output logic               eret_flush,
    output cp0_pkg::word_t     exception_addr
);

    cp0_pkg::word_t ex_base;

    // A faulting instruction must not write CP0 or flush as ERET
    assign commit.mtc0_we  = m1s_valid & m1s_inst_mtc0 & ~m1s_ex;
    assign eret_flush      = m1s_valid & m1s_inst_eret & ~m1s_ex;
    assign commit.eret     = eret_flush;

    assign commit.addr     = cp0_pkg::cp0_addr_t'({m1s_rd, m1s_sel});
    assign commit.wdata    = m1s_alu_result; // mtc0 source operand
    assign commit.ex       = m1s_ex;
    assign commit.bd       = m1s_bd;
    assign commit.exc_type = m1s_exc_type;
    assign commit.pc       = m1s_pc;

    // No refill vector, so the offset is fixed
    assign ex_base        = bev ? cp0_pkg::GENERAL_EX_BASE : ebase;
    assign exception_addr = ex_base + cp0_pkg::GENERAL_EX_OFFSET;

endmodule

//--- verilog/cp0_commit_if.sv
`timescale 1ns/1ps

interface cp0_commit_if;

    logic                mtc0_we;  // Qualified mtc0
    logic                eret;     // Qualified eret
    cp0_pkg::cp0_addr_t  addr;
    cp0_pkg::word_t      wdata;
    logic                ex;
    logic                bd;       // Faulting instruction sits in a delay slot
    cp0_pkg::exc_type_t  exc_type;
    cp0_pkg::word_t      pc;

    modport ctrl (
        output mtc0_we, eret, addr, wdata, ex, bd, exc_type, pc
    );

    modport regs (
        input mtc0_we, eret, addr, wdata, ex, bd, exc_type, pc
    );

endinterface

//--- verilog/cp0_pkg.sv
package cp0_pkg;

    typedef logic [31:0] word_t;

    // Register addresses, {rd, sel}
    typedef enum logic [7:0] {
        BADVADDR = 8'h40, // rd 8
        COUNT    = 8'h48, // rd 9
        COMPARE  = 8'h58, // rd 11
        STATUS   = 8'h60, // rd 12
        CAUSE    = 8'h68, // rd 13
        EPC      = 8'h70, // rd 14
        PRID     = 8'h78, // rd 15 sel 0
        EBASE    = 8'h79  // rd 15 sel 1
    } cp0_addr_t;

    // Exception reported by the memory stage
    typedef enum logic [4:0] {
        EXC_NONE = 5'd0,
        EXC_INT  = 5'd1,
        EXC_ADEL = 5'd2,
        EXC_ADES = 5'd3,
        EXC_SYS  = 5'd4,
        EXC_BP   = 5'd5,
        EXC_RI   = 5'd6,
        EXC_CPU  = 5'd7,
        EXC_OV   = 5'd8,
        EXC_TRAP = 5'd9
    } exc_type_t;

    // Cause ExcCode field encodings
    typedef enum logic [4:0] {
        EC_INT  = 5'd0,
        EC_ADEL = 5'd4,
        EC_ADES = 5'd5,
        EC_SYS  = 5'd8,
        EC_BP   = 5'd9,
        EC_RI   = 5'd10,
        EC_CPU  = 5'd11,
        EC_OV   = 5'd12,
        EC_TR   = 5'd13,
        NO_EX   = 5'd31  // Also the reset value
    } exc_code_t;

    localparam word_t GENERAL_EX_BASE   = 32'hbfc0_0200; // Used while BEV is set
    localparam word_t GENERAL_EX_OFFSET = 32'h0000_0180;
    localparam word_t COMPARE_RESET     = 32'hffff_ffff;

endpackage
